// File: hdl/byte_unpacker.sv
`timescale 1ns/1ps

module byte_unpacker (
    input  logic                    adc_sampleclk,
    input  logic                    reset,
    input  logic                    clear_i,
    input  logic                    low_res_i,
    input  logic                    fifo_read_fifoen_i,
    input  fifo_capture_pkg::word_t slow_dout_i,
    input  logic                    slow_empty_i,
    output logic                    slow_rd_o,
    output logic [7:0]              fifo_read_data_o,
    output logic                    underflow_o
);

    logic [3:0] idx;
    logic [3:0] nib;                // low nibble of the first word of a pair
    logic       underflow_sticky;
    logic       wrap;

    assign wrap        = low_res_i ? (idx == 4'd2) : (idx == 4'd8);
    assign slow_rd_o   = fifo_read_fifoen_i &&
                         (low_res_i ? (idx == 4'd2) : (idx == 4'd3 || idx == 4'd8));
    assign underflow_o = fifo_read_fifoen_i && slow_empty_i;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i) begin
            idx              <= 4'd0;
            underflow_sticky <= 1'b0;
        end else begin
            if (underflow_o)
                underflow_sticky <= 1'b1;
            if (fifo_read_fifoen_i)
                idx <= wrap ? 4'd0 : idx + 4'd1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_read_fifoen_i && !low_res_i && (idx == 4'd3))
            nib <= slow_dout_i[3:0];
    end

    always_comb begin
        fifo_read_data_o = 8'h00;
        if (!underflow_sticky && !slow_empty_i) begin
            if (low_res_i) begin
                // upper 8 bits of each sample
                case (idx)
                    4'd0:    fifo_read_data_o = slow_dout_i[35:28];
                    4'd1:    fifo_read_data_o = slow_dout_i[23:16];
                    4'd2:    fifo_read_data_o = slow_dout_i[11:4];
                    default: fifo_read_data_o = 8'h00;
                endcase
            end else begin
                case (idx)
                    4'd0:    fifo_read_data_o = slow_dout_i[35:28];
                    4'd1:    fifo_read_data_o = slow_dout_i[27:20];
                    4'd2:    fifo_read_data_o = slow_dout_i[19:12];
                    4'd3:    fifo_read_data_o = slow_dout_i[11:4];
                    4'd4:    fifo_read_data_o = {nib, slow_dout_i[35:32]};   // straddles words
                    4'd5:    fifo_read_data_o = slow_dout_i[31:24];
                    4'd6:    fifo_read_data_o = slow_dout_i[23:16];
                    4'd7:    fifo_read_data_o = slow_dout_i[15:8];
                    4'd8:    fifo_read_data_o = slow_dout_i[7:0];
                    default: fifo_read_data_o = 8'h00;
                endcase
            end
        end
    end

    assert property (@(posedge adc_sampleclk) disable iff (reset) idx <= 4'd8);

endmodule

// File: hdl/capture_counters.sv
`timescale 1ns/1ps

module capture_counters (
    input  logic                          adc_sampleclk,
    input  logic                          reset,
    input  fifo_capture_pkg::presample_t  presample_i,
    input  fifo_capture_pkg::count_t      max_samples_i,
    input  fifo_capture_pkg::downsample_t downsample_i,
    input  logic                          fast_wr_i,
    sample_count_if.cnt_mp                cnt
);

    fifo_capture_pkg::downsample_t decim_cnt;
    fifo_capture_pkg::presample_t  presamp_cnt;
    fifo_capture_pkg::count_t      sample_cnt;
    logic [1:0]                    mod3_cnt;

    assign cnt.decim_tick = (decim_cnt == downsample_i);
    // same presample threshold as before: two short of the request
    assign cnt.presamp_almost_full = ({1'b0, presamp_cnt} + 16'd2) >= {1'b0, presample_i};
    assign cnt.limit_reached = (sample_cnt + 16'd1) >= max_samples_i;
    assign cnt.triple_done   = (mod3_cnt == 2'd2);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            decim_cnt   <= '0;
            presamp_cnt <= '0;
            sample_cnt  <= '0;
            mod3_cnt    <= 2'd0;
        end else if (cnt.clear_counts) begin
            decim_cnt   <= '0;
            presamp_cnt <= '0;
            sample_cnt  <= '0;
            mod3_cnt    <= 2'(presample_i % 15'd3);    // presamples already in the fifo
        end else begin
            decim_cnt <= cnt.decim_tick ? '0 : decim_cnt + 1'b1;
            if (cnt.presamp_phase && fast_wr_i)
                presamp_cnt <= presamp_cnt + 1'b1;
            if (cnt.load_presamp) begin
                sample_cnt <= {1'b0, presample_i};  // limit counts from first presample
            end else if (cnt.triggered_phase && fast_wr_i) begin
                sample_cnt <= sample_cnt + 1'b1;
                mod3_cnt   <= (mod3_cnt == 2'd2) ? 2'd0 : mod3_cnt + 2'd1;
            end
        end
    end

    assert property (@(posedge adc_sampleclk) disable iff (reset) mod3_cnt < 2'd3);

endmodule

// File: hdl/capture_fsm.sv
`timescale 1ns/1ps

module capture_fsm (
    input  logic                          adc_sampleclk,
    input  logic                          reset,
    input  logic                          arm_i,
    input  logic                          adc_capture_go_i,
    input  fifo_capture_pkg::presample_t  presample_i,
    input  fifo_capture_pkg::downsample_t downsample_i,
    input  logic                          fast_empty_i,
    input  logic                          packer_idle_i,
    sample_count_if.fsm_mp                cnt,
    output logic                          fifo_clear_o,
    output logic                          write_phase_o,
    output logic                          drain_o,
    output logic                          pack_en_o,
    output logic                          adc_capture_stop_o,
    output logic                          presamp_err_o,
    output logic                          downsample_err_o
);

    fifo_capture_pkg::capture_state_t state;
    logic arm_r;
    logic arm_edge;
    logic armed;
    logic wr;

    assign arm_edge = arm_i && !arm_r;
    assign wr       = cnt.decim_tick && write_phase_o;    // matches fast_wr at the top

    assign write_phase_o = (state == fifo_capture_pkg::PRESAMP_FILLING) ||
                           (state == fifo_capture_pkg::PRESAMP_FULL) ||
                           (state == fifo_capture_pkg::TRIGGERED);
    assign pack_en_o     = (state == fifo_capture_pkg::TRIGGERED) ||
                           (state == fifo_capture_pkg::DONE);
    assign presamp_err_o = (state == fifo_capture_pkg::PRESAMP_FILLING) && adc_capture_go_i;

    assign cnt.clear_counts    = fifo_clear_o;
    assign cnt.presamp_phase   = (state == fifo_capture_pkg::PRESAMP_FILLING);
    assign cnt.triggered_phase = (state == fifo_capture_pkg::TRIGGERED);
    assign cnt.load_presamp    = (state == fifo_capture_pkg::PRESAMP_FULL) && adc_capture_go_i;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r              <= 1'b0;
            fifo_clear_o       <= 1'b0;
            armed              <= 1'b0;
            state              <= fifo_capture_pkg::IDLE;
            drain_o            <= 1'b0;
            adc_capture_stop_o <= 1'b0;
            downsample_err_o   <= 1'b0;
        end else begin
            arm_r        <= arm_i;
            fifo_clear_o <= arm_edge;
            if (fifo_clear_o)
                armed <= 1'b1;                  // armed one cycle after the clear
            // drain the oldest sample one cycle after each full-window write
            drain_o <= (state == fifo_capture_pkg::PRESAMP_FULL) && wr && !adc_capture_go_i;
            if (arm_edge) begin
                state              <= fifo_capture_pkg::IDLE;
                drain_o            <= 1'b0;
                adc_capture_stop_o <= 1'b0;     // falls with fifo_clear
            end else begin
                case (state)
                    fifo_capture_pkg::IDLE: begin
                        downsample_err_o <= (downsample_i != '0) && (presample_i != '0);
                        if (armed && (presample_i != '0)) begin
                            armed <= 1'b0;
                            state <= fifo_capture_pkg::PRESAMP_FILLING;
                        end else if (armed && adc_capture_go_i) begin
                            armed <= 1'b0;
                            state <= fifo_capture_pkg::TRIGGERED;
                        end
                    end
                    fifo_capture_pkg::PRESAMP_FILLING: begin
                        if (adc_capture_go_i)
                            state <= fifo_capture_pkg::TRIGGERED;   // early trigger, flagged
                        else if (cnt.presamp_almost_full)
                            state <= fifo_capture_pkg::PRESAMP_FULL;
                    end
                    fifo_capture_pkg::PRESAMP_FULL: begin
                        if (adc_capture_go_i)
                            state <= fifo_capture_pkg::TRIGGERED;
                    end
                    fifo_capture_pkg::TRIGGERED: begin
                        if (wr && cnt.limit_reached && cnt.triple_done) begin
                            adc_capture_stop_o <= 1'b1;
                            state              <= fifo_capture_pkg::DONE;
                        end
                    end
                    fifo_capture_pkg::DONE: begin
                        if (fast_empty_i && packer_idle_i)
                            state <= fifo_capture_pkg::IDLE;
                    end
                    default: state <= fifo_capture_pkg::IDLE;
                endcase
            end
        end
    end

    // a registered drain must never spill past the presample window
    assert property (@(posedge adc_sampleclk) disable iff (reset)
        drain_o |-> (state == fifo_capture_pkg::PRESAMP_FULL));

endmodule

// File: hdl/fifo_capture_pkg.sv
package fifo_capture_pkg;

    localparam int SAMPLE_W = 12;
    localparam int WORD_W   = 36;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [WORD_W-1:0]   word_t;        // oldest sample in the top 12 bits
    typedef logic [15:0]         count_t;
    typedef logic [14:0]         presample_t;
    typedef logic [12:0]         downsample_t;

    typedef enum logic [2:0] {
        IDLE,
        PRESAMP_FILLING,
        PRESAMP_FULL,
        TRIGGERED,
        DONE
    } capture_state_t;

    // bit positions in the error status
    localparam int ERR_DOWNSAMPLE = 5;
    localparam int ERR_CLIP       = 4;
    localparam int ERR_PRESAMP    = 3;
    localparam int ERR_FAST_OVF   = 2;
    localparam int ERR_SLOW_OVF   = 1;
    localparam int ERR_UNDERFLOW  = 0;

    typedef logic [5:0] err_vec_t;

endpackage

// File: hdl/fifo_capture_top.sv
`timescale 1ns/1ps

module fifo_capture_top #(
    parameter int FAST_DEPTH = 64,
    parameter int SLOW_DEPTH = 64
) (
    input  logic                          adc_sampleclk,
    input  logic                          reset,
    input  fifo_capture_pkg::sample_t     adc_datain_i,
    input  logic                          arm_i,
    input  logic                          adc_capture_go_i,
    input  fifo_capture_pkg::presample_t  presample_i,
    input  fifo_capture_pkg::count_t      max_samples_i,
    input  fifo_capture_pkg::downsample_t downsample_i,
    input  logic                          no_clip_errors_i,
    input  logic                          low_res_i,
    input  logic                          clear_fifo_errors_i,
    input  logic                          fifo_read_fifoen_i,
    output logic                          adc_capture_stop_o,
    output logic                          fifo_read_fifoempty_o,
    output logic [7:0]                    fifo_read_data_o,
    output logic                          error_flag_o,
    output fifo_capture_pkg::err_vec_t    error_stat_o
);

    logic fifo_clear, write_phase, drain, pack_en, presamp_err, downsample_err;
    logic fast_wr, fast_rd, fast_empty, fast_ovf, fast_unf;
    logic slow_wr, slow_rd, slow_full, slow_empty, slow_ovf, slow_unf;
    logic packer_idle, rd_unf, clip;
    fifo_capture_pkg::sample_t  fast_dout;
    fifo_capture_pkg::word_t    word, slow_dout;
    fifo_capture_pkg::err_vec_t err_vec;

    sample_count_if u_cnt_if ();

    assign fast_wr = u_cnt_if.decim_tick && write_phase;
    assign clip    = !no_clip_errors_i && fast_wr &&
                     ((adc_datain_i == '1) || (adc_datain_i == '0));   // rail hit
    assign fifo_read_fifoempty_o = slow_empty;

    capture_fsm u_capture_fsm (
        .adc_sampleclk, .reset, .arm_i, .adc_capture_go_i, .presample_i, .downsample_i,
        .fast_empty_i(fast_empty), .packer_idle_i(packer_idle), .cnt(u_cnt_if.fsm_mp),
        .fifo_clear_o(fifo_clear), .write_phase_o(write_phase), .drain_o(drain),
        .pack_en_o(pack_en), .adc_capture_stop_o, .presamp_err_o(presamp_err),
        .downsample_err_o(downsample_err)
    );

    capture_counters u_capture_counters (
        .adc_sampleclk, .reset, .presample_i, .max_samples_i, .downsample_i,
        .fast_wr_i(fast_wr), .cnt(u_cnt_if.cnt_mp)
    );

    sample_fifo #(.DATA_T(fifo_capture_pkg::sample_t), .DEPTH(FAST_DEPTH)) u_fast_fifo (
        .adc_sampleclk, .reset, .clear_i(fifo_clear), .wr_i(fast_wr), .din_i(adc_datain_i),
        .rd_i(fast_rd), .dout_o(fast_dout), .full_o(), .empty_o(fast_empty),
        .overflow_o(fast_ovf), .underflow_o(fast_unf)
    );

    word_packer u_word_packer (
        .adc_sampleclk, .reset, .clear_i(fifo_clear), .pack_en_i(pack_en), .drain_i(drain),
        .fast_dout_i(fast_dout), .fast_empty_i(fast_empty), .slow_full_i(slow_full),
        .fast_rd_o(fast_rd), .slow_wr_o(slow_wr), .word_o(word), .idle_o(packer_idle)
    );

    sample_fifo #(.DATA_T(fifo_capture_pkg::word_t), .DEPTH(SLOW_DEPTH)) u_slow_fifo (
        .adc_sampleclk, .reset, .clear_i(fifo_clear), .wr_i(slow_wr), .din_i(word),
        .rd_i(slow_rd), .dout_o(slow_dout), .full_o(slow_full), .empty_o(slow_empty),
        .overflow_o(slow_ovf), .underflow_o(slow_unf)
    );

    byte_unpacker u_byte_unpacker (
        .adc_sampleclk, .reset, .clear_i(fifo_clear), .low_res_i, .fifo_read_fifoen_i,
        .slow_dout_i(slow_dout), .slow_empty_i(slow_empty), .slow_rd_o(slow_rd),
        .fifo_read_data_o, .underflow_o(rd_unf)
    );

    always_comb begin
        err_vec = '0;
        err_vec[fifo_capture_pkg::ERR_DOWNSAMPLE] = downsample_err;
        err_vec[fifo_capture_pkg::ERR_CLIP]       = clip;
        err_vec[fifo_capture_pkg::ERR_PRESAMP]    = presamp_err;
        err_vec[fifo_capture_pkg::ERR_FAST_OVF]   = fast_ovf;
        err_vec[fifo_capture_pkg::ERR_SLOW_OVF]   = slow_ovf;
        err_vec[fifo_capture_pkg::ERR_UNDERFLOW]  = rd_unf || slow_unf || fast_unf;
    end

    // sticky status, cleared on arm or on request
    always_ff @(posedge adc_sampleclk) begin
        if (reset || fifo_clear || clear_fifo_errors_i) begin
            error_stat_o <= '0;
            error_flag_o <= 1'b0;
        end else if (err_vec != '0) begin
            error_stat_o <= error_stat_o | err_vec;
            error_flag_o <= 1'b1;
        end
    end

endmodule

// File: hdl/sample_count_if.sv
`timescale 1ns/1ps

interface sample_count_if;

    logic clear_counts;         // arm pulse
    logic presamp_phase;
    logic triggered_phase;
    logic load_presamp;         // trigger taken from presample-full
    logic decim_tick;           // one sample kept out of downsample+1
    logic presamp_almost_full;
    logic limit_reached;
    logic triple_done;          // next triggered write closes a word

    modport fsm_mp (
        output clear_counts, presamp_phase, triggered_phase, load_presamp,
        input  decim_tick, presamp_almost_full, limit_reached, triple_done
    );

    modport cnt_mp (
        input  clear_counts, presamp_phase, triggered_phase, load_presamp,
        output decim_tick, presamp_almost_full, limit_reached, triple_done
    );

endinterface

// File: hdl/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo #(
    parameter type DATA_T = fifo_capture_pkg::sample_t,
    parameter int  DEPTH  = 64
) (
    input  logic  adc_sampleclk,
    input  logic  reset,
    input  logic  clear_i,
    input  logic  wr_i,
    input  DATA_T din_i,
    input  logic  rd_i,
    output DATA_T dout_o,
    output logic  full_o,
    output logic  empty_o,
    output logic  overflow_o,
    output logic  underflow_o
);

    localparam int PTR_W = $clog2(DEPTH);

    DATA_T            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full_o  = (count == (PTR_W + 1)'(DEPTH));
    assign empty_o = (count == '0);
    assign do_wr   = wr_i && !full_o;
    assign do_rd   = rd_i && !empty_o;
    assign dout_o  = mem[rd_ptr];       // show-ahead

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr)
            mem[wr_ptr] <= din_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
        end else begin
            overflow_o  <= wr_i && full_o;      // dropped write
            underflow_o <= rd_i && empty_o;
            if (do_wr)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_rd)
                rd_ptr <= next_ptr(rd_ptr);
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    assert property (@(posedge adc_sampleclk) disable iff (reset)
        count <= (PTR_W + 1)'(DEPTH));

endmodule

// File: hdl/word_packer.sv
`timescale 1ns/1ps

module word_packer (
    input  logic                      adc_sampleclk,
    input  logic                      reset,
    input  logic                      clear_i,
    input  logic                      pack_en_i,
    input  logic                      drain_i,
    input  fifo_capture_pkg::sample_t fast_dout_i,
    input  logic                      fast_empty_i,
    input  logic                      slow_full_i,
    output logic                      fast_rd_o,
    output logic                      slow_wr_o,
    output fifo_capture_pkg::word_t   word_o,
    output logic                      idle_o
);

    localparam int KEEP_W = fifo_capture_pkg::WORD_W - fifo_capture_pkg::SAMPLE_W;

    logic [1:0] phase;
    logic       pack_rd;

    assign pack_rd   = pack_en_i && !fast_empty_i && !slow_full_i;
    assign fast_rd_o = drain_i || pack_rd;      // drained samples are simply dropped
    assign idle_o    = (phase == 2'd0);

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i) begin
            phase     <= 2'd0;
            slow_wr_o <= 1'b0;
        end else begin
            slow_wr_o <= pack_rd && (phase == 2'd2);    // word complete next cycle
            if (pack_rd)
                phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
        end
    end

    // oldest sample ends up in the top bits
    always_ff @(posedge adc_sampleclk) begin
        if (pack_rd)
            word_o <= {word_o[KEEP_W-1:0], fast_dout_i};
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message
verilator --binary --timing --assert -j 0 -f sources.f \
    --top-module tb_fifo_capture -o tb_fifo_capture \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_fifo_capture)
echo "$out"
echo "$out" | grep -q "All tests passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sources.f
hdl/fifo_capture_pkg.sv
hdl/sample_count_if.sv
hdl/sample_fifo.sv
hdl/capture_counters.sv
hdl/capture_fsm.sv
hdl/word_packer.sv
hdl/byte_unpacker.sv
hdl/fifo_capture_top.sv
tb/tb_fifo_capture.sv

// File: tb/tb_fifo_capture.sv
`timescale 1ns/1ps

module tb_fifo_capture;

    logic                          adc_sampleclk;
    logic                          reset;
    fifo_capture_pkg::sample_t     adc_datain_i;
    logic                          arm_i;
    logic                          adc_capture_go_i;
    fifo_capture_pkg::presample_t  presample_i;
    fifo_capture_pkg::count_t      max_samples_i;
    fifo_capture_pkg::downsample_t downsample_i;
    logic                          no_clip_errors_i;
    logic                          low_res_i;
    logic                          clear_fifo_errors_i;
    logic                          fifo_read_fifoen_i;
    logic                          adc_capture_stop_o;
    logic                          fifo_read_fifoempty_o;
    logic [7:0]                    fifo_read_data_o;
    logic                          error_flag_o;
    fifo_capture_pkg::err_vec_t    error_stat_o;

    fifo_capture_pkg::sample_t ramp;
    logic                      force_rail;  // drive the ADC input to all ones
    integer                    seed;
    int                        errors;
    int                        tests_failed;
    logic [7:0]                rx [18];     // bytes read back in one test

    fifo_capture_top #(.FAST_DEPTH(64), .SLOW_DEPTH(64)) u_fifo_capture_top (.*);

    assign adc_datain_i = force_rail ? 12'hfff : ramp;

    initial begin
        adc_sampleclk = 1'b0;
        forever #20 adc_sampleclk = ~adc_sampleclk;
    end

    // ramp stays inside 1..4094 so it never hits a rail
    function automatic fifo_capture_pkg::sample_t ramp_next(input fifo_capture_pkg::sample_t v);
        return (v >= 12'd4094) ? 12'd1 : v + 12'd1;
    endfunction

    function automatic fifo_capture_pkg::sample_t ramp_step(input fifo_capture_pkg::sample_t v,
                                                            input int n);
        fifo_capture_pkg::sample_t r;
        r = v;
        repeat (n) r = ramp_next(r);
        return r;
    endfunction

    always @(negedge adc_sampleclk) ramp <= ramp_next(ramp);

    // full-res byte stream is the words back to back, oldest bits first
    function automatic fifo_capture_pkg::sample_t sample_from_bytes(input int k);
        logic [143:0] stream;
        int           i;
        stream = '0;
        for (i = 0; i < 18; i++)
            stream[143 - 8*i -: 8] = rx[i];
        return stream[143 - 12*k -: 12];
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start);
        if (errors == start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - start);
            tests_failed++;
        end
    endtask

    task automatic wait_for_stop();
        int n;
        n = 0;
        while (!adc_capture_stop_o && n < 400) begin
            @(negedge adc_sampleclk);
            n++;
        end
        if (!adc_capture_stop_o) begin
            $display("timeout at %0t ns: capture stop never rose within 400 cycles", $time);
            errors++;
        end
    endtask

    task automatic read_byte(input bit wait_data, output logic [7:0] data);
        int n;
        n = 0;
        while (wait_data && fifo_read_fifoempty_o && n < 100) begin
            @(negedge adc_sampleclk);
            n++;
        end
        if (wait_data && fifo_read_fifoempty_o) begin
            $display("timeout at %0t ns: no byte became available within 100 cycles", $time);
            errors++;
        end
        data = fifo_read_data_o;            // stable since the last rising edge
        fifo_read_fifoen_i = 1'b1;
        @(negedge adc_sampleclk);
        fifo_read_fifoen_i = 1'b0;
    endtask

    task automatic arm_capture(input int pre, input int max_n, input int decim, input bit low_res);
        presample_i   = 15'(pre);
        max_samples_i = 16'(max_n);
        downsample_i  = 13'(decim);
        low_res_i     = low_res;
        arm_i         = 1'b1;
        @(negedge adc_sampleclk);
        arm_i = 1'b0;
    endtask

    task automatic start_capture(input int pre, input int max_n, input int decim,
                                 input bit low_res, input int go_delay);
        arm_capture(pre, max_n, decim, low_res);
        repeat (go_delay) @(negedge adc_sampleclk);
        adc_capture_go_i = 1'b1;
        wait_for_stop();
        adc_capture_go_i = 1'b0;
    endtask

    task automatic test_basic_low_res();
        int         start;
        int         i;
        logic [7:0] step;
        start = errors;
        check_value(32'(adc_capture_stop_o), 32'd0, "stop after reset");
        check_value(32'(error_flag_o), 32'd0, "error flag after reset");
        check_value(32'(fifo_read_fifoempty_o), 32'd1, "empty after reset");
        start_capture(0, 9, 0, 1'b1, 0);
        for (i = 0; i < 9; i++)
            read_byte(1'b1, rx[i]);
        // 8 bits of a +1 ramp move by 0 or 1
        for (i = 1; i < 9; i++) begin
            step = rx[i] - rx[i-1];
            check_value(32'(step <= 8'd1), 32'd1,
                        $sformatf("low-res byte %0d went %0h -> %0h", i, rx[i-1], rx[i]));
        end
        check_value(32'(fifo_read_fifoempty_o), 32'd1, "empty after 9 low-res bytes");
        check_value(32'(error_stat_o), 32'd0, "error status after basic capture");
        report_test("basic low-res capture", start);
    endtask

    task automatic test_full_res_padding();
        int                        start;
        int                        i;
        int                        n_samp;
        int                        full_bytes;
        fifo_capture_pkg::sample_t s;
        start      = errors;
        n_samp     = ((7 + 2) / 3) * 3;     // limit rounded up to whole words
        full_bytes = (n_samp * 12) / 8;
        start_capture(0, 7, 0, 1'b0, 0);
        for (i = 0; i < 18; i++)
            read_byte(i < full_bytes, rx[i]);
        for (i = 1; i < n_samp - 1; i++)
            check_value(32'(sample_from_bytes(i)), 32'(ramp_next(sample_from_bytes(i - 1))),
                        $sformatf("full-res sample %0d", i));
        // last sample loses its low nibble to the underflowing half-pair
        s = ramp_next(sample_from_bytes(n_samp - 2));
        check_value(32'(rx[full_bytes - 1]), 32'(s[11:4]), "upper bits of last sample");
        for (i = full_bytes; i < 18; i++)
            check_value(32'(rx[i]), 32'h0, $sformatf("byte %0d past the data", i));
        check_value(32'(error_stat_o[fifo_capture_pkg::ERR_UNDERFLOW]), 32'd1,
                    "underflow after reading past the last word");
        report_test("full-res padding", start);
    endtask

    task automatic test_downsample();
        int start;
        int i;
        start = errors;
        start_capture(0, 6, 2, 1'b0, 0);
        check_value(32'(adc_capture_stop_o), 32'd1, "stop after downsampled capture");
        for (i = 0; i < 9; i++)
            read_byte(1'b1, rx[i]);
        for (i = 1; i < 6; i++)
            check_value(32'(sample_from_bytes(i)), 32'(ramp_step(sample_from_bytes(i - 1), 3)),
                        $sformatf("downsampled sample %0d", i));
        check_value(32'(fifo_read_fifoempty_o), 32'd1, "empty after downsampled readout");
        check_value(32'(error_stat_o), 32'd0, "error status after downsampled capture");
        report_test("downsample by 3", start);
    endtask

    task automatic test_presample();
        int start;
        int i;
        start = errors;
        start_capture(4, 12, 0, 1'b0, 20);
        for (i = 0; i < 18; i++)
            read_byte(1'b1, rx[i]);
        for (i = 1; i < 12; i++)
            check_value(32'(sample_from_bytes(i)), 32'(ramp_next(sample_from_bytes(i - 1))),
                        $sformatf("presample run sample %0d", i));
        check_value(32'(fifo_read_fifoempty_o), 32'd1, "empty after presample readout");
        check_value(32'(error_flag_o), 32'd0, "error flag after presample capture");
        report_test("presample window", start);
    endtask

    task automatic test_errors();
        int         start;
        logic [7:0] d;
        start = errors;
        arm_capture(0, 3, 0, 1'b1);
        repeat (2) @(negedge adc_sampleclk);    // fifo clear has to pass first
        read_byte(1'b0, d);
        check_value(32'(d), 32'h0, "byte read while empty");
        check_value(32'(error_stat_o[fifo_capture_pkg::ERR_UNDERFLOW]), 32'd1,
                    "underflow bit after empty read");
        check_value(32'(error_flag_o), 32'd1, "error flag after empty read");
        clear_fifo_errors_i = 1'b1;
        @(negedge adc_sampleclk);
        clear_fifo_errors_i = 1'b0;
        check_value(32'(error_stat_o), 32'd0, "error status after clear");
        check_value(32'(error_flag_o), 32'd0, "error flag after clear");
        force_rail = 1'b1;
        start_capture(0, 3, 0, 1'b1, 0);
        force_rail = 1'b0;
        check_value(32'(error_stat_o[fifo_capture_pkg::ERR_CLIP]), 32'd1, "clip bit on rail");
        no_clip_errors_i = 1'b1;
        force_rail       = 1'b1;
        start_capture(0, 3, 0, 1'b1, 0);
        force_rail       = 1'b0;
        no_clip_errors_i = 1'b0;
        check_value(32'(error_stat_o), 32'd0, "error status with clip errors masked");
        report_test("error status", start);
    endtask

    initial begin
        seed = 12;
        ramp = 12'(32'd1 + ($unsigned($random(seed)) % 32'd4094));
        force_rail          = 1'b0;
        reset               = 1'b1;
        arm_i               = 1'b0;
        adc_capture_go_i    = 1'b0;
        presample_i         = '0;
        max_samples_i       = '0;
        downsample_i        = '0;
        no_clip_errors_i    = 1'b0;
        low_res_i           = 1'b1;
        clear_fifo_errors_i = 1'b0;
        fifo_read_fifoen_i  = 1'b0;
        errors              = 0;
        tests_failed        = 0;
        repeat (3) @(negedge adc_sampleclk);
        reset = 1'b0;
        @(negedge adc_sampleclk);

        test_basic_low_res();
        test_full_res_padding();
        test_downsample();
        test_presample();
        test_errors();

        $display("summary: %0d of 5 tests failed, %0d errors in total", tests_failed, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
